// File: rtl/core_pkg.sv
// shared definitions for the out-of-order integer slice
// sizes, opcodes, instruction layout and the dispatch and rob records
`default_nettype none

package core_pkg;

    // datapath and storage sizes
    localparam int xlen     = 16;
    localparam int num_regs = 16;
    localparam int rob_size = 8;

    typedef logic [3:0] reg_idx_t;
    // entries 1..8, zero means the value sits in the register file
    typedef logic [3:0] rob_tag_t;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4,
        addi   = 3'd5,
        nop    = 3'd6
    } alu_op_t;

    // 16-bit instruction word, bit 12 reserved
    typedef struct packed {
        logic [2:0] opcode;
        logic       spare;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
    } inst_word_t;

    typedef struct packed {
        logic            valid;
        alu_op_t         op;
        reg_idx_t        dest;
        logic            has_dest;
        reg_idx_t        src_a;
        reg_idx_t        src_b;
        logic [xlen-1:0] imm;
        logic            use_imm;
    } dp_packet_t;

    typedef struct packed {
        logic            valid;
        logic            issued;
        logic            complete;
        alu_op_t         op;
        reg_idx_t        dest;
        logic            has_dest;
        rob_tag_t        tag_a;
        rob_tag_t        tag_b;
        logic [xlen-1:0] value_a;
        logic [xlen-1:0] value_b;
        logic            ready_a;
        logic            ready_b;
        logic [xlen-1:0] result;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: rtl/dispatch_if.sv
// dispatch channel from decode into the reorder buffer
// map table listens to the same handshake
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if;
    import core_pkg::*;

    logic       valid;
    logic       ready;
    dp_packet_t packet;
    // slot the next accepted packet lands in
    rob_tag_t   tail_tag;

    modport source  (output valid, output packet, input ready, input tail_tag);
    modport sink    (input valid, input packet, output ready, output tail_tag);
    modport monitor (input valid, input packet, input ready, input tail_tag);
endinterface

`default_nettype wire

// File: rtl/issue_if.sv
// issue strobe from the rob to the alu, and the common data bus back
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
    import core_pkg::*;

    logic            valid;
    rob_tag_t        rob_tag;
    alu_op_t         op;
    // carried along so the result bus can name the register
    reg_idx_t        dest;
    logic [xlen-1:0] value_a;
    logic [xlen-1:0] value_b;

    modport source (output valid, output rob_tag, output op, output dest,
                    output value_a, output value_b);
    modport sink   (input valid, input rob_tag, input op, input dest,
                    input value_a, input value_b);
endinterface

interface cdb_if;
    import core_pkg::*;

    logic            valid;
    rob_tag_t        rob_tag;
    reg_idx_t        dest;
    logic [xlen-1:0] value;

    modport source (output valid, output rob_tag, output dest, output value);
    modport sink   (input valid, input rob_tag, input dest, input value);
endinterface

`default_nettype wire

// File: rtl/inst_decode.sv
// instruction decode, word to dispatch packet
// stall comes straight from rob ready
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  core_pkg::inst_word_t inst_word,
    output logic                 inst_ready,
    dispatch_if.source           dispatch
);
    import core_pkg::*;

    alu_op_t     op;
    logic        stalled;

    // unused opcode 7 decodes as nop
    assign op = (inst_word.opcode > 3'd6) ? nop : alu_op_t'(inst_word.opcode);

    always_comb begin
        dispatch.packet          = '0;
        dispatch.packet.valid    = inst_valid;
        dispatch.packet.op       = op;
        dispatch.packet.dest     = inst_word.rd;
        // r0 writes and nops produce nothing architectural
        dispatch.packet.has_dest = (op != nop) && (inst_word.rd != '0);
        dispatch.packet.use_imm  = (op == addi);
        dispatch.packet.imm      = {{(xlen - 4){1'b0}}, inst_word.rs2};
        // nop reads nothing and addi reads rs1 only
        dispatch.packet.src_a    = (op == nop) ? '0 : inst_word.rs1;
        dispatch.packet.src_b    = (op == nop || op == addi) ? '0 : inst_word.rs2;
    end

    assign dispatch.valid = inst_valid;
    assign inst_ready     = dispatch.ready;

    // stall flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stalled <= 1'b0;
        end else begin
            stalled <= inst_valid && !dispatch.ready;
        end
    end

    // a stalled word is held unchanged for the next cycle
    a_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
        stalled |-> inst_valid && $stable(inst_word));
endmodule

`default_nettype wire

// File: rtl/map_table.sv
// register map table, arch register to producing rob tag
// cleared at retire while still current, wiped on flush
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic               clock,
    input  logic               reset,
    input  logic               flush,
    dispatch_if.monitor        dispatch,
    cdb_if.sink                cdb,
    input  logic               retire_valid,
    input  core_pkg::reg_idx_t retire_dest,
    input  core_pkg::rob_tag_t retire_tag,
    input  core_pkg::reg_idx_t src_a,
    input  core_pkg::reg_idx_t src_b,
    output core_pkg::rob_tag_t tag_a,
    output core_pkg::rob_tag_t tag_b
);
    import core_pkg::*;

    rob_tag_t            tags [num_regs];
    // producer has broadcast its result
    logic [num_regs-1:0] done;

    // r0 never has a producer
    assign tag_a = (src_a == '0) ? '0 : tags[src_a];
    assign tag_b = (src_b == '0) ? '0 : tags[src_b];

    always_ff @(posedge clock or posedge reset) begin
        if (reset || flush) begin
            tags <= '{default: '0};
            done <= '0;
        end else begin
            if (cdb.valid && tags[cdb.dest] == cdb.rob_tag)
                done[cdb.dest] <= 1'b1;
            // only clear if no younger writer took over
            if (retire_valid && tags[retire_dest] == retire_tag)
                tags[retire_dest] <= '0;
            // new producer wins over a same-cycle retire
            if (dispatch.valid && dispatch.ready && dispatch.packet.has_dest) begin
                tags[dispatch.packet.dest] <= dispatch.tail_tag;
                done[dispatch.packet.dest] <= 1'b0;
            end
        end
    end

    // current producer must have hit the bus before it retires
    a_retire_after_cdb: assert property (@(posedge clock) disable iff (reset)
        retire_valid && tags[retire_dest] == retire_tag |-> done[retire_dest]);
endmodule

`default_nettype wire

// File: rtl/rob.sv
// eight-entry reorder buffer
// operand capture at dispatch, in-order issue, in-order retire at head
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         flush,
    dispatch_if.sink                     dispatch,
    issue_if.source                      issue,
    cdb_if.sink                          cdb,
    input  core_pkg::rob_tag_t           tag_a,
    input  core_pkg::rob_tag_t           tag_b,
    output core_pkg::reg_idx_t           src_a,
    output core_pkg::reg_idx_t           src_b,
    input  logic [core_pkg::xlen-1:0]    reg_value_a,
    input  logic [core_pkg::xlen-1:0]    reg_value_b,
    output logic                         retire_valid,
    output core_pkg::reg_idx_t           retire_dest,
    output core_pkg::rob_tag_t           retire_tag,
    output logic [core_pkg::xlen-1:0]    retire_value
);
    import core_pkg::*;

    rob_entry_t entries [1:rob_size];
    rob_tag_t   head;
    rob_tag_t   tail;
    rob_tag_t   issue_ptr;
    rob_entry_t new_entry;
    logic       full;
    logic       accept;
    logic       issue_go;
    logic       head_done;
    // valid bit of every slot
    logic [rob_size:1] occupied;

    // wrap 8 back to 1
    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == rob_tag_t'(rob_size)) ? rob_tag_t'(1) : rob_tag_t'(t + 4'd1);
    endfunction

    // {ready, value} for one source operand
    function automatic logic [xlen:0] capture(input rob_tag_t tag,
                                              input logic [xlen-1:0] reg_val,
                                              input rob_entry_t producer,
                                              input logic cdb_hit,
                                              input logic [xlen-1:0] cdb_val);
        if (tag == '0)
            return {1'b1, reg_val};
        if (producer.complete)
            return {1'b1, producer.result};
        // result on the bus this very cycle
        if (cdb_hit)
            return {1'b1, cdb_val};
        return '0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // dispatch side
    ////////////////////////////////////////////////////////////////////////////

    // tail slot still occupied means all eight in use
    assign full              = entries[tail].valid;
    assign dispatch.ready    = !full && !flush;
    assign dispatch.tail_tag = tail;
    assign accept            = dispatch.valid && dispatch.ready;
    assign src_a             = dispatch.packet.src_a;
    assign src_b             = dispatch.packet.src_b;

    always_comb begin
        for (int i = 1; i <= rob_size; i++)
            occupied[i] = entries[i].valid;
    end

    always_comb begin
        new_entry          = '0;
        new_entry.valid    = 1'b1;
        new_entry.op       = dispatch.packet.op;
        new_entry.dest     = dispatch.packet.dest;
        new_entry.has_dest = dispatch.packet.has_dest;
        new_entry.tag_a    = tag_a;
        {new_entry.ready_a, new_entry.value_a} = capture(tag_a, reg_value_a,
            entries[tag_a], cdb.valid && cdb.rob_tag == tag_a, cdb.value);
        if (dispatch.packet.use_imm) begin
            // immediate ready at once
            new_entry.ready_b = 1'b1;
            new_entry.value_b = dispatch.packet.imm;
        end else begin
            new_entry.tag_b = tag_b;
            {new_entry.ready_b, new_entry.value_b} = capture(tag_b, reg_value_b,
                entries[tag_b], cdb.valid && cdb.rob_tag == tag_b, cdb.value);
        end
    end

    // oldest unissued entry only
    assign issue_go = entries[issue_ptr].valid && !entries[issue_ptr].issued
                   && entries[issue_ptr].ready_a && entries[issue_ptr].ready_b;

    // no-dest entries leave the head silently
    assign head_done    = entries[head].valid && entries[head].complete;
    assign retire_valid = head_done && entries[head].has_dest;
    assign retire_dest  = entries[head].dest;
    assign retire_tag   = head;
    assign retire_value = entries[head].result;

    ////////////////////////////////////////////////////////////////////////////
    // state update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset || flush) begin
            entries     <= '{default: '0};
            head        <= rob_tag_t'(1);
            tail        <= rob_tag_t'(1);
            issue_ptr   <= rob_tag_t'(1);
            issue.valid <= 1'b0;
        end else begin
            // bus result plus wakeup of waiting operands
            if (cdb.valid) begin
                for (int i = 1; i <= rob_size; i++) begin
                    if (entries[i].valid && entries[i].issued
                            && cdb.rob_tag == rob_tag_t'(i)) begin
                        entries[i].result   <= cdb.value;
                        entries[i].complete <= 1'b1;
                    end
                    if (entries[i].valid && !entries[i].ready_a
                            && entries[i].tag_a == cdb.rob_tag) begin
                        entries[i].value_a <= cdb.value;
                        entries[i].ready_a <= 1'b1;
                    end
                    if (entries[i].valid && !entries[i].ready_b
                            && entries[i].tag_b == cdb.rob_tag) begin
                        entries[i].value_b <= cdb.value;
                        entries[i].ready_b <= 1'b1;
                    end
                end
            end
            // one-cycle issue strobe
            issue.valid <= issue_go;
            if (issue_go) begin
                entries[issue_ptr].issued <= 1'b1;
                issue_ptr <= next_tag(issue_ptr);
            end
            if (head_done) begin
                entries[head].valid <= 1'b0;
                head <= next_tag(head);
            end
            if (accept) begin
                entries[tail] <= new_entry;
                tail <= next_tag(tail);
            end
        end
    end

    // issue payload
    always_ff @(posedge clock) begin
        issue.rob_tag <= issue_ptr;
        issue.op      <= entries[issue_ptr].op;
        issue.dest    <= entries[issue_ptr].dest;
        issue.value_a <= entries[issue_ptr].value_a;
        issue.value_b <= entries[issue_ptr].value_b;
    end

    // tail slot taken only once every slot is taken
    a_full_all_valid: assert property (@(posedge clock) disable iff (reset)
        full |-> &occupied);

    // strobed entry had both operands in hand
    a_issue_ready: assert property (@(posedge clock) disable iff (reset)
        issue.valid |-> entries[issue.rob_tag].valid && entries[issue.rob_tag].issued
                     && entries[issue.rob_tag].ready_a && entries[issue.rob_tag].ready_b);

    // stale bus tags only right after a flush
    a_cdb_tag_live: assert property (@(posedge clock) disable iff (reset)
        cdb.valid && !flush && !$past(flush) && !$past(flush, 2)
        |-> entries[cdb.rob_tag].valid && entries[cdb.rob_tag].issued);
endmodule

`default_nettype wire

// File: rtl/alu_pipe.sv
// two-stage integer alu
// operand latch, then compute onto the common data bus
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
    input  logic    clock,
    input  logic    reset,
    issue_if.sink   issue,
    cdb_if.source   cdb
);
    import core_pkg::*;

    // stage 1 operand latch
    logic            s1_valid;
    rob_tag_t        s1_tag;
    alu_op_t         s1_op;
    reg_idx_t        s1_dest;
    logic [xlen-1:0] s1_a;
    logic [xlen-1:0] s1_b;
    logic [xlen-1:0] result;

    // results wrap at 16 bits
    always_comb begin
        case (s1_op)
            add, addi: result = s1_a + s1_b;
            sub:       result = s1_a - s1_b;
            and_op:    result = s1_a & s1_b;
            or_op:     result = s1_a | s1_b;
            xor_op:    result = s1_a ^ s1_b;
            default:   result = '0;
        endcase
    end

    // valid bits
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            cdb.valid <= 1'b0;
        end else begin
            s1_valid  <= issue.valid;
            cdb.valid <= s1_valid;
        end
    end

    // payload
    always_ff @(posedge clock) begin
        s1_tag      <= issue.rob_tag;
        s1_op       <= issue.op;
        s1_dest     <= issue.dest;
        s1_a        <= issue.value_a;
        s1_b        <= issue.value_b;
        cdb.rob_tag <= s1_tag;
        cdb.dest    <= s1_dest;
        cdb.value   <= result;
    end

    // fixed two-cycle latency, always ready
    a_two_cycle: assert property (@(posedge clock) disable iff (reset)
        issue.valid |-> ##2 cdb.valid);
endmodule

`default_nettype wire

// File: rtl/arch_regfile.sv
// committed register file, written at retire
// r0 reads as zero, two combinational read ports
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      retire_valid,
    input  core_pkg::reg_idx_t        retire_dest,
    input  core_pkg::reg_idx_t        read_a,
    input  core_pkg::reg_idx_t        read_b,
    input  logic [core_pkg::xlen-1:0] retire_value,
    output logic [core_pkg::xlen-1:0] value_a,
    output logic [core_pkg::xlen-1:0] value_b
);
    import core_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            regs <= '{default: '0};
        else if (retire_valid && retire_dest != '0)
            regs[retire_dest] <= retire_value;
    end

    // no bypass, rob covers a same-cycle retire
    assign value_a = (read_a == '0) ? '0 : regs[read_a];
    assign value_b = (read_b == '0) ? '0 : regs[read_b];
endmodule

`default_nettype wire

// File: rtl/ooo_core_top.sv
// out-of-order core slice top level
// decode, map table, rob, alu and committed registers
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  core_pkg::inst_word_t      inst_word,
    input  logic                      flush,
    output logic                      inst_ready,
    output logic                      retire_valid,
    output core_pkg::reg_idx_t        retire_dest,
    output logic [core_pkg::xlen-1:0] retire_value
);
    import core_pkg::*;

    rob_tag_t        retire_tag;
    rob_tag_t        tag_a;
    rob_tag_t        tag_b;
    reg_idx_t        src_a;
    reg_idx_t        src_b;
    logic [xlen-1:0] reg_value_a;
    logic [xlen-1:0] reg_value_b;

    dispatch_if dispatch_bus ();
    issue_if    issue_bus ();
    cdb_if      cdb_bus ();

    inst_decode inst_decode_inst (.clock, .reset, .inst_valid, .inst_word, .inst_ready,
                                  .dispatch(dispatch_bus));

    map_table map_table_inst (.clock, .reset, .flush, .dispatch(dispatch_bus), .cdb(cdb_bus),
                              .retire_valid, .retire_dest, .retire_tag,
                              .src_a, .src_b, .tag_a, .tag_b);

    rob rob_inst (.clock, .reset, .flush, .dispatch(dispatch_bus), .issue(issue_bus),
                  .cdb(cdb_bus), .tag_a, .tag_b, .src_a, .src_b, .reg_value_a, .reg_value_b,
                  .retire_valid, .retire_dest, .retire_tag, .retire_value);

    alu_pipe alu_pipe_inst (.clock, .reset, .issue(issue_bus), .cdb(cdb_bus));

    // rob sources double as register read addresses
    arch_regfile arch_regfile_inst (.clock, .reset, .retire_valid, .retire_dest,
                                    .read_a(src_a), .read_b(src_b), .retire_value,
                                    .value_a(reg_value_a), .value_b(reg_value_b));
endmodule

`default_nettype wire

// File: verif/tb_ooo_core.sv
// testbench for the out-of-order core slice
// replays the golden record stream and checks every retirement in order
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import core_pkg::*;

    localparam int half_period = 50;
    localparam int max_wait    = 200;

    logic            clock;
    logic            reset;
    logic            inst_valid;
    inst_word_t      inst_word;
    logic            flush;
    logic            inst_ready;
    logic            retire_valid;
    reg_idx_t        retire_dest;
    logic [xlen-1:0] retire_value;

    // three words per record: kind, a, b
    logic [15:0] records [0:255];
    logic [7:0]  ptr;
    logic [15:0] kind;
    // {dest, value} in program order
    logic [19:0] expected_q [$];
    logic [19:0] front;
    int          value_errors;
    int          other_errors;
    int          retire_count;
    int          stall_seen;
    logic        timed_out;
    logic        done;

    ooo_core_top ooo_core_top_inst (.clock, .reset, .inst_valid, .inst_word, .flush,
                                    .inst_ready, .retire_valid, .retire_dest, .retire_value);

    always #(half_period) clock = ~clock;

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // hold the word until an edge takes it, called on a falling edge
    task automatic send_inst(input logic [15:0] word);
        int   cycles;
        logic taken;
        cycles     = 0;
        taken      = 1'b0;
        inst_valid = 1'b1;
        inst_word  = inst_word_t'(word);
        while (!taken && cycles < max_wait) begin
            // mid low phase, inputs settled
            #(half_period / 2);
            taken = inst_ready;
            if (!taken)
                stall_seen++;
            @(negedge clock);
            cycles++;
        end
        inst_valid = 1'b0;
        if (!taken) begin
            $display("timeout: instruction %h was never accepted", word);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    // all expected retirements seen, then a stretch with no retire at all
    task automatic drain_pipeline();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (expected_q.size() != 0 && cycles < max_wait) begin
            @(posedge clock);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout: %0d expected retirements never happened", expected_q.size());
            other_errors++;
            timed_out = 1'b1;
        end else begin
            cycles = 0;
            while (quiet < 6 && cycles < max_wait) begin
                @(negedge clock);
                cycles++;
                quiet = retire_valid ? 0 : quiet + 1;
            end
            if (quiet < 6) begin
                $display("timeout: retirements kept coming after the stream drained");
                other_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // retire monitor, outputs are registered state so stable at falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("unexpected retirement to r%0d with value %h", retire_dest,
                         retire_value);
                other_errors++;
            end else begin
                front = expected_q.pop_front();
                retire_count++;
                check_value($sformatf("retire %0d dest", retire_count),
                            {12'b0, front[19:16]}, {12'b0, retire_dest});
                check_value($sformatf("retire %0d value", retire_count),
                            front[15:0], retire_value);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_word    = '0;
        flush        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        retire_count = 0;
        stall_seen   = 0;
        timed_out    = 1'b0;
        done         = 1'b0;
        ptr          = '0;
        $readmemh("verif/golden_retire.txt", records);
        repeat (2) @(negedge clock);
        reset = 1'b0;

        while (!done && !timed_out) begin
            kind = records[ptr];
            case (kind)
                16'h0000: done = 1'b1;
                16'h0001: send_inst(records[ptr + 8'd1]);
                16'h0002: expected_q.push_back({records[ptr + 8'd1][3:0], records[ptr + 8'd2]});
                16'h0003: begin
                    // squash a lone instruction right after it lands
                    drain_pipeline();
                    if (!timed_out)
                        send_inst(records[ptr + 8'd1]);
                    flush = 1'b1;
                    @(negedge clock);
                    flush = 1'b0;
                end
                default: begin
                    $display("unknown record kind %h at word %0d", kind, ptr);
                    other_errors++;
                    done = 1'b1;
                end
            endcase
            if (ptr > 8'd249)
                done = 1'b1;
            ptr = ptr + 8'd3;
        end

        if (!timed_out)
            drain_pipeline();
        // the dependent chain must have filled the buffer at least once
        check_value("inst_ready drop while full", 16'd1, {15'b0, stall_seen != 0});

        $display("retired %0d, value mismatches %0d, other errors %0d",
                 retire_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: verif/golden_retire.txt
// kind a b: 1 dispatch word a, 2 expect retire of r(a) with value b
// 3 drain, dispatch word a, then flush, 0 end of stream
// independent addi
1 a105 0000
2 0001 0005
1 a203 0000
2 0002 0003
1 a40f 0000
2 0004 000f
// dependent chain with forwarding
1 0512 0000
2 0005 0008
1 a557 0000
2 0005 000f
1 2651 0000
2 0006 000a
// r0 write never retires, r0 reads zero
1 a019 0000
1 0702 0000
2 0007 0003
// sub and logic ops, 0 minus 1 wraps
1 a901 0000
2 0009 0001
1 2809 0000
2 0008 ffff
1 4a85 0000
2 000a 000f
1 6b12 0000
2 000b 0007
1 8c81 0000
2 000c fffa
// squashed write to r1, reader sees the committed 5
3 a10a 0000
1 0d12 0000
2 000d 0008
// ten back-to-back dependent ops fill the buffer
1 a301 0000
2 0003 0001
1 0333 0000
2 0003 0002
1 0333 0000
2 0003 0004
1 0333 0000
2 0003 0008
1 0333 0000
2 0003 0010
1 0333 0000
2 0003 0020
1 0333 0000
2 0003 0040
1 0333 0000
2 0003 0080
1 0333 0000
2 0003 0100
1 0333 0000
2 0003 0200
0 0000 0000

// File: tb.f
rtl/core_pkg.sv
rtl/dispatch_if.sv
rtl/issue_if.sv
rtl/inst_decode.sv
rtl/map_table.sv
rtl/rob.sv
rtl/alu_pipe.sv
rtl/arch_regfile.sv
rtl/ooo_core_top.sv
verif/tb_ooo_core.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert --timescale 1ns/1ps -f tb.f \
        --top-module tb_ooo_core -Mdir obj_dir -o sim_tb; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
